// ==== flist.f ====
+incdir+verilog
verilog/tabla_pkg.sv
verilog/ctrl_regs.sv
verilog/mem_interface.sv
verilog/pe_array.sv
verilog/tabla_top.sv
tb/tabla_checker.sv
tb/tabla_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tabla_tb -f flist.f -o tabla_sim

# keep the log even when the simulation exits with an error
./obj_dir/tabla_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// ==== tb/tabla_checker.sv ====
module tabla_checker (
    input  logic                    aclk,
    input  logic                    reset,
    input  logic                    busy,
    input  tabla_pkg::addr_t        ar_addr,
    input  logic                    ar_valid,
    input  logic                    ar_ready,
    input  logic                    r_ready,
    input  tabla_pkg::mem_wr_t      mem_wr,
    input  logic                    w_valid,
    input  logic                    w_ready,
    input  logic                    done,
    input  logic                    host_rvalid
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned ar_fails = 0;
    int unsigned w_fails = 0;
    int unsigned done_fails = 0;
    int unsigned idle_fails = 0;
    int unsigned reset_fails = 0;
    int unsigned fail_count;

    assign fail_count = ar_fails + w_fails + done_fails + idle_fails + reset_fails;

// ******************************
// channel handshakes
// ******************************
    ar_hold: assert property (@(posedge aclk) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else
    begin
        ar_fails++;
        $error("read address dropped or changed before ar_ready");
    end

    w_hold: assert property (@(posedge aclk) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(mem_wr))
    else
    begin
        w_fails++;
        $error("write dropped or changed before w_ready");
    end

// ******************************
// control rules
// ******************************
    done_pulse: assert property (@(posedge aclk) disable iff (reset)
        done |=> !done)
    else
    begin
        done_fails++;
        $error("done high for more than one cycle");
    end

    // no traffic outside a job
    idle_quiet: assert property (@(posedge aclk) disable iff (reset)
        !busy |-> !ar_valid && !w_valid)
    else
    begin
        idle_fails++;
        $error("memory request while not busy");
    end

    reset_quiet: assert property (@(posedge aclk)
        reset |=> !ar_valid && !r_ready && !w_valid && !done && !host_rvalid)
    else
    begin
        reset_fails++;
        $error("outputs not low after reset");
    end

endmodule

bind tabla_top tabla_checker u_checker (
    .aclk           ( ACLK          ),
    .reset          ( reset         ),
    .busy           ( busy          ),
    .ar_addr        ( ar_addr       ),
    .ar_valid       ( ar_valid      ),
    .ar_ready       ( ar_ready      ),
    .r_ready        ( r_ready       ),
    .mem_wr         ( mem_wr        ),
    .w_valid        ( w_valid       ),
    .w_ready        ( w_ready       ),
    .done           ( done          ),
    .host_rvalid    ( host_rvalid   )
);

// ==== tb/tabla_tb.sv ====
`include "tabla_config.svh"

module tabla_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h9fcd579f;
    localparam int MEM_WORDS = 1 << `TABLA_ADDR_WIDTH;
    localparam int TOTAL_WORDS = 16 + 3 * 12 + 8 + 0;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_WORDS + 500;

    logic                   aclk = 1'b0;
    logic                   reset;
    tabla_pkg::host_req_t   host_req;
    tabla_pkg::word_t       host_rdata;
    logic                   host_rvalid;
    tabla_pkg::addr_t       ar_addr;
    logic                   ar_valid;
    logic                   ar_ready;
    tabla_pkg::word_t       r_data;
    logic                   r_valid;
    logic                   r_ready;
    tabla_pkg::mem_wr_t     mem_wr;
    logic                   w_valid;
    logic                   w_ready;
    logic                   done;

    tabla_pkg::word_t       mem [0:MEM_WORDS-1];
    logic [31:0]            rng_state;
    logic                   rd_pending;
    tabla_pkg::addr_t       rd_addr;
    int unsigned            ar_total;       // model side counters
    int unsigned            wr_total;
    int unsigned            done_count;
    int unsigned            data_errors;
    int unsigned            ar_base;        // sequence side
    int unsigned            wr_base;
    int unsigned            check_errors;
    logic                   stall_en;
    string                  test_name;
    tabla_pkg::addr_t       job_src;
    tabla_pkg::addr_t       job_dst;
    tabla_pkg::op_t         job_op;
    tabla_pkg::word_t       src_words [$];  // source snapshot of the running job

    tabla_top u_dut (
        .ACLK           ( aclk          ),
        .reset          ( reset         ),
        .host_req       ( host_req      ),
        .host_rdata     ( host_rdata    ),
        .host_rvalid    ( host_rvalid   ),
        .ar_addr        ( ar_addr       ),
        .ar_valid       ( ar_valid      ),
        .ar_ready       ( ar_ready      ),
        .r_data         ( r_data        ),
        .r_valid        ( r_valid       ),
        .r_ready        ( r_ready       ),
        .mem_wr         ( mem_wr        ),
        .w_valid        ( w_valid       ),
        .w_ready        ( w_ready       ),
        .done           ( done          )
    );

    always #2 aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic draw_ready();
        rng_state = xorshift32(rng_state);
        return !stall_en || (rng_state[1:0] != 2'b00);  // 1 in 4 stalls
    endfunction

    // lane rule, lane k is bits 4k+3..4k
    function automatic tabla_pkg::word_t apply_op(input tabla_pkg::word_t src,
                                                  input tabla_pkg::op_t op);
        tabla_pkg::word_t res;
        int unsigned lane;
        int unsigned val;
        res = '0;
        for (lane = 0; lane < `TABLA_NUM_LANES; lane++)
        begin
            val = (src >> (4 * lane)) & 32'hf;
            case (op)
                tabla_pkg::op_incr:   val = (val + 1) % 16;
                tabla_pkg::op_invert: val = 15 - val;
                tabla_pkg::op_shift:  val = (val * 2) % 16;
                default:              val = val;
            endcase
            res = res | (tabla_pkg::word_t'(val) << (4 * lane));
        end
        return res;
    endfunction

// ******************************
// memory model
// ******************************
    initial
    begin : mem_model
        int unsigned wr_idx;
        tabla_pkg::addr_t exp_addr;
        tabla_pkg::word_t exp_data;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_data = '0;
        w_ready = 1'b0;
        rd_pending = 1'b0;
        rd_addr = '0;
        ar_total = 0;
        wr_total = 0;
        done_count = 0;
        data_errors = 0;
        rng_state = SEED;
        for (int a = 0; a < MEM_WORDS; a++)
            mem[a] = xorshift32(32'(a) ^ SEED);
        forever
        begin
            @(posedge aclk);
            #1;
            if (rd_pending)
            begin
                r_valid = draw_ready();
                r_data = mem[rd_addr];
                if (r_valid && r_ready)
                    rd_pending = 1'b0;  // beat taken at next edge
            end
            else
                r_valid = 1'b0;
            ar_ready = draw_ready();
            if (ar_valid && ar_ready)
            begin
                exp_addr = job_src + tabla_pkg::addr_t'(ar_total - ar_base);
                assert (ar_addr == exp_addr)
                else
                begin
                    data_errors++;
                    $display("Mismatch %s read address: expected %h, actual %h",
                             test_name, exp_addr, ar_addr);
                end
                rd_addr = ar_addr;
                rd_pending = 1'b1;
                ar_total++;
            end
            w_ready = draw_ready();
            if (w_valid && w_ready)
            begin
                wr_idx = wr_total - wr_base;
                exp_addr = job_dst + tabla_pkg::addr_t'(wr_idx);
                assert (mem_wr.addr == exp_addr)
                else
                begin
                    data_errors++;
                    $display("Mismatch %s write address: expected %h, actual %h",
                             test_name, exp_addr, mem_wr.addr);
                end
                if (wr_idx < src_words.size())
                begin
                    exp_data = apply_op(src_words[wr_idx], job_op);
                    assert (mem_wr.data == exp_data)
                    else
                    begin
                        data_errors++;
                        $display("Mismatch %s write data: expected %h, actual %h",
                                 test_name, exp_data, mem_wr.data);
                    end
                end
                else
                begin
                    data_errors++;
                    $display("Write beyond the programmed size in %s", test_name);
                end
                mem[mem_wr.addr] = mem_wr.data;
                wr_total++;
            end
            if (done)
                done_count++;
        end
    end

// ******************************
// host driver
// ******************************
    task automatic reg_write(input tabla_pkg::reg_addr_t addr, input tabla_pkg::word_t data);
        @(posedge aclk);
        #1;
        host_req.wr_en = 1'b1;
        host_req.rd_en = 1'b0;
        host_req.addr = addr;
        host_req.wdata = data;
        @(posedge aclk);
        #1;
        host_req = '0;
    endtask

    task automatic reg_read(input tabla_pkg::reg_addr_t addr, output tabla_pkg::word_t data);
        @(posedge aclk);
        #1;
        host_req = '0;
        host_req.rd_en = 1'b1;
        host_req.addr = addr;
        @(posedge aclk);
        #1;
        host_req = '0;
        assert (host_rvalid)
        else
        begin
            check_errors++;
            $display("No read response for register %0d in %s", addr, test_name);
        end
        data = host_rdata;
    endtask

    task automatic expect_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act == exp)
        else
        begin
            check_errors++;
            $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic wait_done();
        do
        begin
            @(posedge aclk);
            #1;
        end
        while (!done);
    endtask

    // program, start, wait, then check traffic counts and registers
    task automatic run_job(input string name, input tabla_pkg::addr_t src,
                           input tabla_pkg::addr_t dst, input tabla_pkg::size_t size,
                           input tabla_pkg::op_t op, input logic stalls, input logic restart);
        tabla_pkg::word_t rd_val;
        int unsigned done_start;
        test_name = name;
        job_src = src;
        job_dst = dst;
        job_op = op;
        stall_en = stalls;
        src_words.delete();
        for (int k = 0; k < size; k++)
            src_words.push_back(mem[src + tabla_pkg::addr_t'(k)]);
        ar_base = ar_total;
        wr_base = wr_total;
        done_start = done_count;
        reg_write(`TABLA_REG_SRC, tabla_pkg::word_t'(src));
        reg_write(`TABLA_REG_DST, tabla_pkg::word_t'(dst));
        reg_write(`TABLA_REG_SIZE, tabla_pkg::word_t'(size));
        reg_write(`TABLA_REG_CTRL, tabla_pkg::word_t'({op, 1'b1}));
        if (restart)
            reg_write(`TABLA_REG_CTRL, tabla_pkg::word_t'({tabla_pkg::op_pass, 1'b1}));
        wait_done();
        repeat (8) @(posedge aclk);
        #1;
        expect_value("read count", tabla_pkg::word_t'(size), ar_total - ar_base);
        expect_value("write count", tabla_pkg::word_t'(size), wr_total - wr_base);
        expect_value("done pulses", 32'd1, done_count - done_start);
        reg_read(`TABLA_REG_SRC, rd_val);
        expect_value("SRC", tabla_pkg::word_t'(src), rd_val);
        reg_read(`TABLA_REG_DST, rd_val);
        expect_value("DST", tabla_pkg::word_t'(dst), rd_val);
        reg_read(`TABLA_REG_SIZE, rd_val);
        expect_value("SIZE", tabla_pkg::word_t'(size), rd_val);
        reg_read(`TABLA_REG_STATUS, rd_val);
        expect_value("STATUS", 32'h2, rd_val);     // done set, busy clear
        reg_read(`TABLA_REG_RD_WORDS, rd_val);
        expect_value("RD_WORDS", tabla_pkg::word_t'(size), rd_val);
        reg_read(`TABLA_REG_WR_WORDS, rd_val);
        expect_value("WR_WORDS", tabla_pkg::word_t'(size), rd_val);
        reg_read(`TABLA_REG_CYCLES, rd_val);
        assert (rd_val >= 3 * size)
        else
        begin
            check_errors++;
            $display("Busy cycle count %0d in %s is below three cycles per word",
                     rd_val, test_name);
        end
    endtask

    task automatic report_counts();
        $display("Data mismatches: %0d, other check errors: %0d, assertion failures: %0d",
                  data_errors, check_errors, u_dut.u_checker.fail_count);
    endtask

// ******************************
// test sequence
// ******************************
    initial
    begin : main_seq
        tabla_pkg::word_t status;
        check_errors = 0;
        ar_base = 0;
        wr_base = 0;
        stall_en = 1'b0;
        test_name = "reset";
        job_src = '0;
        job_dst = '0;
        job_op = tabla_pkg::op_pass;
        host_req = '0;
        reset = 1'b1;
        repeat (4) @(posedge aclk);
        #1;
        reset = 1'b0;
        assert (!ar_valid && !w_valid && !done && !host_rvalid)
        else
        begin
            check_errors++;
            $display("Outputs are not idle after reset");
        end
        reg_read(`TABLA_REG_STATUS, status);
        expect_value("STATUS", 32'h0, status);

        run_job("pass_no_stall", 16'h0100, 16'h1000, 9'd16, tabla_pkg::op_pass, 1'b0, 1'b0);
        run_job("incr_stall", 16'h0200, 16'h2000, 9'd12, tabla_pkg::op_incr, 1'b1, 1'b0);
        run_job("invert_stall", 16'h0300, 16'h3000, 9'd12, tabla_pkg::op_invert, 1'b1, 1'b0);
        run_job("shift_stall", 16'h0400, 16'h4000, 9'd12, tabla_pkg::op_shift, 1'b1, 1'b0);
        run_job("start_while_busy", 16'h0500, 16'h5000, 9'd8, tabla_pkg::op_incr, 1'b1, 1'b1);
        run_job("empty_job", 16'h0600, 16'h6000, 9'd0, tabla_pkg::op_invert, 1'b0, 1'b0);

        report_counts();
        if (data_errors == 0 && check_errors == 0 && u_dut.u_checker.fail_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin : watchdog
        int unsigned cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_counts();
        $display("Errors found");
        $finish;
    end

endmodule

// ==== verilog/ctrl_regs.sv ====
`include "tabla_config.svh"

module ctrl_regs (
    input  logic                    ACLK,
    input  logic                    reset,
    input  tabla_pkg::host_req_t    host_req,
    output tabla_pkg::word_t        host_rdata,
    output logic                    host_rvalid,
    output tabla_pkg::job_t         job,
    output logic                    start,
    input  logic                    busy,
    input  tabla_pkg::job_stats_t   job_stats
);

    tabla_pkg::addr_t   src_q;
    tabla_pkg::addr_t   dst_q;
    tabla_pkg::size_t   size_q;
    tabla_pkg::op_t     op_q;
    logic               done_q;
    tabla_pkg::cntr_t   rd_words_q;
    tabla_pkg::cntr_t   wr_words_q;
    tabla_pkg::cntr_t   cycles_q;
    tabla_pkg::word_t   rd_sel;
    logic               ctrl_wr;

    // CTRL is locked while a job runs or a start is already pending
    assign ctrl_wr = host_req.wr_en && (host_req.addr == `TABLA_REG_CTRL) && !busy && !start;

    assign job.src  = src_q;
    assign job.dst  = dst_q;
    assign job.size = size_q;
    assign job.op   = op_q;

// ******************************
// job descriptor and start
// ******************************
    always_ff @(posedge ACLK)
    begin
        if (reset)
        begin
            src_q  <= '0;
            dst_q  <= '0;
            size_q <= '0;
            op_q   <= tabla_pkg::op_pass;
            start  <= 1'b0;
        end
        else
        begin
            start <= ctrl_wr && host_req.wdata[0];  // single cycle pulse
            if (ctrl_wr)
                op_q <= tabla_pkg::op_t'(host_req.wdata[2:1]);
            if (host_req.wr_en && host_req.addr == `TABLA_REG_SRC)
                src_q <= tabla_pkg::addr_t'(host_req.wdata);
            if (host_req.wr_en && host_req.addr == `TABLA_REG_DST)
                dst_q <= tabla_pkg::addr_t'(host_req.wdata);
            if (host_req.wr_en && host_req.addr == `TABLA_REG_SIZE)
                size_q <= tabla_pkg::size_t'(host_req.wdata);
        end
    end

// ******************************
// status and perf counters
// ******************************
    always_ff @(posedge ACLK)
    begin
        if (reset || start)
        begin
            done_q     <= 1'b0;     // sticky done cleared by new job
            rd_words_q <= '0;
            wr_words_q <= '0;
            cycles_q   <= '0;
        end
        else
        begin
            if (job_stats.job_done)
                done_q <= 1'b1;
            if (job_stats.rd_beat)
                rd_words_q <= rd_words_q + 1'b1;
            if (job_stats.wr_beat)
                wr_words_q <= wr_words_q + 1'b1;
            if (busy)
                cycles_q <= cycles_q + 1'b1;
        end
    end

    always_comb
    begin
        case (host_req.addr)
            `TABLA_REG_CTRL:     rd_sel = tabla_pkg::word_t'({op_q, 1'b0});
            `TABLA_REG_SRC:      rd_sel = tabla_pkg::word_t'(src_q);
            `TABLA_REG_DST:      rd_sel = tabla_pkg::word_t'(dst_q);
            `TABLA_REG_SIZE:     rd_sel = tabla_pkg::word_t'(size_q);
            `TABLA_REG_STATUS:   rd_sel = tabla_pkg::word_t'({done_q, busy});
            `TABLA_REG_RD_WORDS: rd_sel = tabla_pkg::word_t'(rd_words_q);
            `TABLA_REG_WR_WORDS: rd_sel = tabla_pkg::word_t'(wr_words_q);
            default:             rd_sel = tabla_pkg::word_t'(cycles_q);
        endcase
    end

    always_ff @(posedge ACLK)
    begin
        if (reset)
            host_rvalid <= 1'b0;
        else
            host_rvalid <= host_req.rd_en;
        if (host_req.rd_en)
            host_rdata <= rd_sel;   // read data one cycle after strobe
    end

endmodule

// ==== verilog/mem_interface.sv ====
module mem_interface (
    input  logic                    ACLK,
    input  logic                    reset,
    input  tabla_pkg::job_t         job,
    input  logic                    start,
    output logic                    busy,

    // read address
    output tabla_pkg::addr_t        ar_addr,
    output logic                    ar_valid,
    input  logic                    ar_ready,

    // read data
    input  tabla_pkg::word_t        r_data,
    input  logic                    r_valid,
    output logic                    r_ready,

    // write
    output tabla_pkg::mem_wr_t      mem_wr,
    output logic                    w_valid,
    input  logic                    w_ready,

    // PE array
    output tabla_pkg::word_t        pe_data,
    output logic                    pe_valid,
    input  tabla_pkg::word_t        result,
    input  logic                    result_valid,

    output tabla_pkg::job_stats_t   job_stats
);

    tabla_pkg::mem_state_t  state;
    tabla_pkg::job_t        job_q;
    tabla_pkg::size_t       idx;        // current word of the job
    tabla_pkg::word_t       wr_data_q;
    logic                   rd_hs;
    logic                   wr_hs;
    logic                   last_word;

    assign rd_hs     = r_valid && r_ready;
    assign wr_hs     = w_valid && w_ready;
    assign last_word = (tabla_pkg::size_t'(idx + 1'b1) == job_q.size);

// ******************************
// channel outputs
// ******************************
    assign busy     = (state != tabla_pkg::st_idle);
    assign ar_valid = (state == tabla_pkg::st_rd_addr);
    assign r_ready  = (state == tabla_pkg::st_rd_data);
    assign w_valid  = (state == tabla_pkg::st_write);

    // idx is stable outside st_write so both addresses hold under stall
    assign ar_addr     = job_q.src + tabla_pkg::addr_t'(idx);
    assign mem_wr.addr = job_q.dst + tabla_pkg::addr_t'(idx);
    assign mem_wr.data = wr_data_q;

    // PE stage registers the beat itself
    assign pe_data  = r_data;
    assign pe_valid = rd_hs;

// ******************************
// job FSM
// ******************************
    always_ff @(posedge ACLK)
    begin
        if (reset)
        begin
            state     <= tabla_pkg::st_idle;
            idx       <= '0;
            job_stats <= '0;
        end
        else
        begin
            job_stats.rd_beat  <= rd_hs;
            job_stats.wr_beat  <= wr_hs;
            job_stats.job_done <= 1'b0;
            case (state)
                tabla_pkg::st_idle:
                begin
                    if (start)
                    begin
                        idx <= '0;
                        if (job.size == '0)
                            job_stats.job_done <= 1'b1;    // empty job, no traffic
                        else
                            state <= tabla_pkg::st_rd_addr;
                    end
                end
                tabla_pkg::st_rd_addr:
                begin
                    if (ar_ready)
                        state <= tabla_pkg::st_rd_data;
                end
                tabla_pkg::st_rd_data:
                begin
                    if (r_valid)
                        state <= tabla_pkg::st_process;
                end
                tabla_pkg::st_process:
                begin
                    if (result_valid)
                        state <= tabla_pkg::st_write;
                end
                tabla_pkg::st_write:
                begin
                    if (w_ready)
                    begin
                        if (last_word)
                        begin
                            state              <= tabla_pkg::st_idle;
                            job_stats.job_done <= 1'b1;
                        end
                        else
                        begin
                            idx   <= idx + 1'b1;
                            state <= tabla_pkg::st_rd_addr;
                        end
                    end
                end
                default:
                    state <= tabla_pkg::st_idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge ACLK)
    begin
        if (state == tabla_pkg::st_idle && start)
            job_q <= job;           // descriptor frozen for the whole job
        if (result_valid)
            wr_data_q <= result;
    end

endmodule

// ==== verilog/pe_array.sv ====
`include "tabla_config.svh"

module pe_array (
    input  logic                ACLK,
    input  logic                reset,
    input  tabla_pkg::op_t      op,
    input  tabla_pkg::word_t    pe_data,
    input  logic                pe_valid,
    output tabla_pkg::word_t    result,
    output logic                result_valid
);

    tabla_pkg::word_t   result_d;

// ******************************
// lane PEs
// ******************************
    genvar i;
    generate
    for (i = 0; i < `TABLA_NUM_LANES; i = i + 1)
    begin : g_lane
        tabla_pkg::lane_t lane_in;
        tabla_pkg::lane_t lane_out;

        assign lane_in = pe_data[i*`TABLA_LANE_WIDTH +: `TABLA_LANE_WIDTH];

        always_comb
        begin
            case (op)
                tabla_pkg::op_incr:   lane_out = tabla_pkg::lane_t'(lane_in + 1'b1);
                tabla_pkg::op_invert: lane_out = ~lane_in;
                tabla_pkg::op_shift:  lane_out = tabla_pkg::lane_t'(lane_in << 1);
                default:              lane_out = lane_in;     // pass
            endcase
        end

        assign result_d[i*`TABLA_LANE_WIDTH +: `TABLA_LANE_WIDTH] = lane_out;
    end
    endgenerate

// ******************************
// output stage
// ******************************
    always_ff @(posedge ACLK)
    begin
        if (reset)
            result_valid <= 1'b0;
        else
            result_valid <= pe_valid;   // one cycle latency
        if (pe_valid)
            result <= result_d;         // held until next beat
    end

endmodule

// ==== verilog/tabla_config.svh ====
`ifndef TABLA_CONFIG_SVH
`define TABLA_CONFIG_SVH

// ******************************
// datapath geometry
// ******************************
`define TABLA_LANE_WIDTH        4       // bits per lane
`define TABLA_NUM_LANES         8       // lanes per memory word
`define TABLA_ADDR_WIDTH        16      // word address
`define TABLA_SIZE_WIDTH        9       // max 511 words per job
`define TABLA_CNTR_WIDTH        16      // perf counters

// ******************************
// host register map
// ******************************
`define TABLA_REG_ADDR_WIDTH    3
`define TABLA_REG_CTRL          3'd0    // [0] start, [2:1] op
`define TABLA_REG_SRC           3'd1
`define TABLA_REG_DST           3'd2
`define TABLA_REG_SIZE          3'd3
`define TABLA_REG_STATUS        3'd4    // [0] busy, [1] done sticky
`define TABLA_REG_RD_WORDS      3'd5
`define TABLA_REG_WR_WORDS      3'd6
`define TABLA_REG_CYCLES        3'd7

`endif

// ==== verilog/tabla_pkg.sv ====
`include "tabla_config.svh"

package tabla_pkg;

    typedef logic [`TABLA_LANE_WIDTH-1:0]                    lane_t;
    typedef logic [`TABLA_LANE_WIDTH*`TABLA_NUM_LANES-1:0]   word_t;
    typedef logic [`TABLA_ADDR_WIDTH-1:0]                    addr_t;
    typedef logic [`TABLA_SIZE_WIDTH-1:0]                    size_t;
    typedef logic [`TABLA_CNTR_WIDTH-1:0]                    cntr_t;
    typedef logic [`TABLA_REG_ADDR_WIDTH-1:0]                reg_addr_t;

    typedef enum logic [1:0] {
        op_pass   = 2'd0,   // lane unchanged
        op_incr   = 2'd1,   // lane + 1, wraps
        op_invert = 2'd2,
        op_shift  = 2'd3    // lane << 1, msb dropped
    } op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_rd_addr,
        st_rd_data,
        st_process,
        st_write
    } mem_state_t;

    // ******************************
    // bundles
    // ******************************
    typedef struct packed {
        logic       wr_en;
        logic       rd_en;
        reg_addr_t  addr;
        word_t      wdata;
    } host_req_t;

    typedef struct packed {
        addr_t      src;
        addr_t      dst;
        size_t      size;
        op_t        op;
    } job_t;

    typedef struct packed {
        addr_t      addr;
        word_t      data;
    } mem_wr_t;

    typedef struct packed {
        logic       rd_beat;    // one read data beat taken
        logic       wr_beat;    // one write accepted
        logic       job_done;
    } job_stats_t;

endpackage

// ==== verilog/tabla_top.sv ====
module tabla_top (
    input  logic                    ACLK,
    input  logic                    reset,

    // host register port
    input  tabla_pkg::host_req_t    host_req,
    output tabla_pkg::word_t        host_rdata,
    output logic                    host_rvalid,

    // memory side
    output tabla_pkg::addr_t        ar_addr,
    output logic                    ar_valid,
    input  logic                    ar_ready,
    input  tabla_pkg::word_t        r_data,
    input  logic                    r_valid,
    output logic                    r_ready,
    output tabla_pkg::mem_wr_t      mem_wr,
    output logic                    w_valid,
    input  logic                    w_ready,

    output logic                    done
);

    tabla_pkg::job_t        job;
    tabla_pkg::job_stats_t  job_stats;
    tabla_pkg::word_t       pe_data;
    tabla_pkg::word_t       result;
    logic                   start;
    logic                   busy;
    logic                   pe_valid;
    logic                   result_valid;

    assign done = job_stats.job_done;

// ******************************
// host registers
// ******************************
    ctrl_regs u_ctrl_regs (
        .ACLK           ( ACLK          ),
        .reset          ( reset         ),
        .host_req       ( host_req      ),
        .host_rdata     ( host_rdata    ),
        .host_rvalid    ( host_rvalid   ),
        .job            ( job           ),
        .start          ( start         ),
        .busy           ( busy          ),
        .job_stats      ( job_stats     )
    );

// ******************************
// memory interface
// ******************************
    mem_interface u_mem_if (
        .ACLK           ( ACLK          ),
        .reset          ( reset         ),
        .job            ( job           ),
        .start          ( start         ),
        .busy           ( busy          ),
        .ar_addr        ( ar_addr       ),
        .ar_valid       ( ar_valid      ),
        .ar_ready       ( ar_ready      ),
        .r_data         ( r_data        ),
        .r_valid        ( r_valid       ),
        .r_ready        ( r_ready       ),
        .mem_wr         ( mem_wr        ),
        .w_valid        ( w_valid       ),
        .w_ready        ( w_ready       ),
        .pe_data        ( pe_data       ),
        .pe_valid       ( pe_valid      ),
        .result         ( result        ),
        .result_valid   ( result_valid  ),
        .job_stats      ( job_stats     )
    );

// ******************************
// PE lanes
// ******************************
    pe_array u_pe_array (
        .ACLK           ( ACLK          ),
        .reset          ( reset         ),
        .op             ( job.op        ),  // CTRL locked while busy
        .pe_data        ( pe_data       ),
        .pe_valid       ( pe_valid      ),
        .result         ( result        ),
        .result_valid   ( result_valid  )
    );

endmodule
